// ==== common/uart_link_pkg.sv ====
package uart_link_pkg;

    localparam int CLKS_PER_BIT = 8;
    localparam logic [7:0] START_FLAG = 8'hA5;

    // response ring buffer depth and its index width
    localparam int CTRL_FIFO_SIZE = 4;
    localparam int CTRL_FIFO_BITS = 2;

    localparam int REG_ADDR_BITS = 4;

    typedef enum logic [7:0] {
        CMD_WRITE = 8'h57,
        CMD_READ  = 8'h52
    } uart_cmd_t;

    typedef enum logic [7:0] {
        RES_NONE  = 8'd0,
        RES_ACK   = 8'd1,
        RES_NAK   = 8'd2,
        RES_PRINT = 8'd3
    } uart_res_t;

    typedef enum logic [2:0] {
        TX_CTRL_IDLE,
        TX_CTRL_RES,
        TX_CTRL_LEN,
        TX_CTRL_PAYLOAD,
        TX_CTRL_CHECKSUM
    } uart_tx_ctrl_t;

    // one queued response, len is 0 for ack/nak and 4 for print
    typedef struct packed {
        logic [7:0]  res;
        logic [2:0]  len;
        logic [31:0] data;
    } uart_tx_entry_t;

endpackage

// ==== uart_rx/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rstn,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t                                       state;
    logic                                            rx_meta;
    logic                                            rx_sync;
    logic [$clog2(uart_link_pkg::CLKS_PER_BIT)-1:0] clk_cnt;
    logic [2:0]                                      bit_idx;
    logic [7:0]                                      shreg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync)
                        state <= RX_START;
                end
                RX_START: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == uart_link_pkg::CLKS_PER_BIT / 2 - 1) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // a glitch, not a start bit
                    end
                end
                RX_DATA: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == uart_link_pkg::CLKS_PER_BIT - 1) begin
                        shreg   <= {rx_sync, shreg[7:1]};  // lsb arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                default: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == uart_link_pkg::CLKS_PER_BIT - 1) begin
                        // bytes with a low stop bit are framing errors and get dropped
                        rx_valid <= rx_sync;
                        rx_data  <= shreg;
                        state    <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== uart_rx/uart_cmd_decode.sv ====
`timescale 1ns/1ps

module uart_cmd_decode (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic [7:0]                             rx_data,
    input  logic                                   rx_valid,
    output logic                                   cmd_write,
    output logic                                   cmd_read,
    output logic                                   cmd_error,
    output logic [uart_link_pkg::REG_ADDR_BITS-1:0] cmd_addr,
    output logic [31:0]                            cmd_wdata
);

    typedef enum logic [2:0] {
        DEC_WAIT_START,
        DEC_CMD,
        DEC_LEN,
        DEC_PAYLOAD,
        DEC_CHECKSUM
    } dec_state_t;

    dec_state_t  state;
    logic [7:0]  sum;
    logic [7:0]  cmd;
    logic [7:0]  len;
    logic [7:0]  byte_cnt;
    logic [39:0] payload;
    logic        len_ok;

    // the payload register holds still until the next frame starts
    assign cmd_addr  = payload[uart_link_pkg::REG_ADDR_BITS-1:0];
    assign cmd_wdata = payload[39:8];

    always_comb begin
        len_ok = 1'b0;
        if (cmd == uart_link_pkg::CMD_WRITE)
            len_ok = (len == 8'd5);
        else if (cmd == uart_link_pkg::CMD_READ)
            len_ok = (len == 8'd1);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= DEC_WAIT_START;
            sum       <= '0;
            cmd       <= '0;
            len       <= '0;
            byte_cnt  <= '0;
            cmd_write <= 1'b0;
            cmd_read  <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            cmd_write <= 1'b0;
            cmd_read  <= 1'b0;
            cmd_error <= 1'b0;
            if (rx_valid) begin
                sum <= sum + rx_data;
                case (state)
                    DEC_WAIT_START: begin
                        sum <= rx_data;
                        if (rx_data == uart_link_pkg::START_FLAG)
                            state <= DEC_CMD;
                    end
                    DEC_CMD: begin
                        cmd   <= rx_data;
                        state <= DEC_LEN;
                    end
                    DEC_LEN: begin
                        len      <= rx_data;
                        byte_cnt <= '0;
                        state    <= (rx_data == 8'd0) ? DEC_CHECKSUM : DEC_PAYLOAD;
                    end
                    DEC_PAYLOAD: begin
                        if (byte_cnt < 8'd5)
                            payload[byte_cnt[2:0]*8 +: 8] <= rx_data;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == len - 1'b1)
                            state <= DEC_CHECKSUM;
                    end
                    default: begin
                        // unknown commands fail len_ok as well
                        if (sum != rx_data || !len_ok)
                            cmd_error <= 1'b1;
                        else if (cmd == uart_link_pkg::CMD_WRITE)
                            cmd_write <= 1'b1;
                        else
                            cmd_read  <= 1'b1;
                        state <= DEC_WAIT_START;
                    end
                endcase
            end
        end
    end

endmodule

// ==== logic/uart_cmd_exec.sv ====
`timescale 1ns/1ps

module uart_cmd_exec (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   cmd_write,
    input  logic                                   cmd_read,
    input  logic                                   cmd_error,
    input  logic [uart_link_pkg::REG_ADDR_BITS-1:0] cmd_addr,
    input  logic [31:0]                            cmd_wdata,
    output uart_link_pkg::uart_res_t               res,
    output logic                                   print_en,
    output logic [31:0]                            print_data
);

    logic [31:0] regs [2**uart_link_pkg::REG_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2**uart_link_pkg::REG_ADDR_BITS; i++)
                regs[i] <= '0;
        end else if (cmd_write) begin
            regs[cmd_addr] <= cmd_wdata;
        end
    end

    // one response per command strobe, RES_NONE otherwise
    always_ff @(posedge clk) begin
        if (!rstn) begin
            res      <= uart_link_pkg::RES_NONE;
            print_en <= 1'b0;
        end else begin
            res      <= uart_link_pkg::RES_NONE;
            print_en <= 1'b0;
            if (cmd_error)
                res <= uart_link_pkg::RES_NAK;
            else if (cmd_write)
                res <= uart_link_pkg::RES_ACK;
            else if (cmd_read)
                print_en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_read)
            print_data <= regs[cmd_addr];
    end

endmodule

// ==== uart_tx/uart_tx_ctrl.sv ====
`timescale 1ns/1ps

module uart_tx_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  uart_link_pkg::uart_res_t res,
    input  logic                     print_en,
    input  logic [31:0]              print_data,
    input  logic                     tx_ready,
    output logic [7:0]               tx_data,
    output logic                     tx_valid
);

    uart_link_pkg::uart_tx_entry_t tx_fifo [uart_link_pkg::CTRL_FIFO_SIZE];

    // top bit of each pointer is the wrap flag
    logic [uart_link_pkg::CTRL_FIFO_BITS:0] wr_ptr;
    logic [uart_link_pkg::CTRL_FIFO_BITS:0] rd_ptr;
    logic                                   fifo_empty;
    logic                                   fifo_full;

    uart_link_pkg::uart_tx_ctrl_t  tx_state;
    uart_link_pkg::uart_tx_entry_t active_entry;
    logic [1:0]                    pay_idx;
    logic [7:0]                    pay_byte;
    logic [7:0]                    checksum;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[uart_link_pkg::CTRL_FIFO_BITS] !=
                         rd_ptr[uart_link_pkg::CTRL_FIFO_BITS]) &&
                        (wr_ptr[uart_link_pkg::CTRL_FIFO_BITS-1:0] ==
                         rd_ptr[uart_link_pkg::CTRL_FIFO_BITS-1:0]);

    assign pay_byte = active_entry.data[pay_idx*8 +: 8];

    // responses arriving while full are lost
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (!fifo_full) begin
            if (res == uart_link_pkg::RES_ACK || res == uart_link_pkg::RES_NAK) begin
                tx_fifo[wr_ptr[uart_link_pkg::CTRL_FIFO_BITS-1:0]] <= {res, 3'd0, 32'd0};
                wr_ptr <= wr_ptr + 1'b1;
            end else if (print_en) begin
                tx_fifo[wr_ptr[uart_link_pkg::CTRL_FIFO_BITS-1:0]] <=
                    {uart_link_pkg::RES_PRINT, 3'd4, print_data};
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // every branch below runs only when tx_ready is high, so the byte on
    // tx_data is taken and the next one goes out on the same edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr   <= '0;
            tx_state <= uart_link_pkg::TX_CTRL_IDLE;
            tx_data  <= '0;
            tx_valid <= 1'b0;
            pay_idx  <= '0;
            checksum <= '0;
        end else if (tx_ready) begin
            case (tx_state)
                uart_link_pkg::TX_CTRL_IDLE: begin
                    pay_idx <= '0;
                    if (!fifo_empty) begin
                        active_entry <= tx_fifo[rd_ptr[uart_link_pkg::CTRL_FIFO_BITS-1:0]];
                        rd_ptr       <= rd_ptr + 1'b1;
                        tx_data      <= uart_link_pkg::START_FLAG;
                        tx_valid     <= 1'b1;
                        checksum     <= uart_link_pkg::START_FLAG;
                        tx_state     <= uart_link_pkg::TX_CTRL_RES;
                    end else begin
                        tx_valid <= 1'b0;  // the last checksum byte has gone
                    end
                end
                uart_link_pkg::TX_CTRL_RES: begin
                    tx_data  <= active_entry.res;
                    checksum <= checksum + active_entry.res;
                    tx_state <= uart_link_pkg::TX_CTRL_LEN;
                end
                uart_link_pkg::TX_CTRL_LEN: begin
                    tx_data  <= {5'd0, active_entry.len};
                    checksum <= checksum + {5'd0, active_entry.len};
                    if (active_entry.len == 3'd0)
                        tx_state <= uart_link_pkg::TX_CTRL_CHECKSUM;
                    else
                        tx_state <= uart_link_pkg::TX_CTRL_PAYLOAD;
                end
                uart_link_pkg::TX_CTRL_PAYLOAD: begin
                    tx_data  <= pay_byte;
                    checksum <= checksum + pay_byte;
                    pay_idx  <= pay_idx + 1'b1;
                    if ({1'b0, pay_idx} == active_entry.len - 3'd1)
                        tx_state <= uart_link_pkg::TX_CTRL_CHECKSUM;
                end
                default: begin
                    tx_data  <= checksum;
                    tx_state <= uart_link_pkg::TX_CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== uart_tx/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       tx
);

    logic [$clog2(uart_link_pkg::CLKS_PER_BIT)-1:0] clk_cnt;
    logic [3:0]                                      bit_cnt;
    logic [8:0]                                      shreg;  // data bits then the stop bit

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_ready <= 1'b1;
            tx       <= 1'b1;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
        end else if (tx_ready) begin
            if (tx_valid) begin
                shreg    <= {1'b1, tx_data};
                tx       <= 1'b0;  // start bit
                tx_ready <= 1'b0;
                clk_cnt  <= '0;
                bit_cnt  <= '0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            if (clk_cnt == uart_link_pkg::CLKS_PER_BIT - 1) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    tx_ready <= 1'b1;  // stop bit has run its full length
                end else begin
                    tx      <= shreg[0];
                    shreg   <= {1'b1, shreg[8:1]};
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/uart_link_top.sv ====
`timescale 1ns/1ps

module uart_link_top (
    input  logic clk,
    input  logic rstn,
    input  logic rx,
    output logic tx
);

    logic [7:0]                              rx_data;
    logic                                    rx_valid;
    logic                                    cmd_write;
    logic                                    cmd_read;
    logic                                    cmd_error;
    logic [uart_link_pkg::REG_ADDR_BITS-1:0] cmd_addr;
    logic [31:0]                             cmd_wdata;
    uart_link_pkg::uart_res_t                res;
    logic                                    print_en;
    logic [31:0]                             print_data;
    logic [7:0]                              tx_data;
    logic                                    tx_valid;
    logic                                    tx_ready;

    uart_rx i_uart_rx (
        .clk      (clk),
        .rstn     (rstn),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_cmd_decode i_uart_cmd_decode (
        .clk       (clk),
        .rstn      (rstn),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .cmd_write (cmd_write),
        .cmd_read  (cmd_read),
        .cmd_error (cmd_error),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata)
    );

    uart_cmd_exec i_uart_cmd_exec (
        .clk        (clk),
        .rstn       (rstn),
        .cmd_write  (cmd_write),
        .cmd_read   (cmd_read),
        .cmd_error  (cmd_error),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .res        (res),
        .print_en   (print_en),
        .print_data (print_data)
    );

    uart_tx_ctrl i_uart_tx_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .res        (res),
        .print_en   (print_en),
        .print_data (print_data),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rstn     (rstn),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

endmodule

// ==== verification/uart_link_checker.sv ====
`timescale 1ns/1ps

module uart_link_checker (
    input logic                                   clk,
    input logic                                   rstn,
    input uart_link_pkg::uart_tx_ctrl_t           tx_state,
    input logic [7:0]                             tx_data,
    input logic                                   tx_valid,
    input logic                                   tx_ready,
    input logic                                   fifo_full,
    input logic                                   fifo_empty
);

    int fail_count = 0;

    hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rstn)
        (tx_valid && !tx_ready) |=> $stable(tx_data)
    ) else begin
        $error("tx_data changed while tx_valid waited for tx_ready");
        fail_count++;
    end

    // every frame opens with the start flag
    start_flag_first: assert property (
        @(posedge clk) disable iff (!rstn)
        (tx_state == uart_link_pkg::TX_CTRL_IDLE) ##1
        (tx_state != uart_link_pkg::TX_CTRL_IDLE) |-> (tx_data == uart_link_pkg::START_FLAG)
    ) else begin
        $error("frame left idle without the start flag on tx_data");
        fail_count++;
    end

    full_and_empty: assert property (
        @(posedge clk) disable iff (!rstn)
        !(fifo_full && fifo_empty)
    ) else begin
        $error("ring buffer flagged full and empty at once");
        fail_count++;
    end

    valid_low_after_reset: assert property (
        @(posedge clk) !rstn |=> !tx_valid
    ) else begin
        $error("tx_valid was high in the cycle after reset");
        fail_count++;
    end

endmodule

bind uart_tx_ctrl uart_link_checker i_uart_link_checker (
    .clk        (clk),
    .rstn       (rstn),
    .tx_state   (tx_state),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
);

// ==== verification/uart_link_tb.sv ====
`timescale 1ns/1ps

module uart_link_tb;

    logic        clk = 1'b0;
    logic        rstn;
    logic        rx;
    logic        tx;
    logic [15:0] lfsr_state = 16'd56;
    logic [31:0] model_regs [16];  // what the register file should hold
    logic [7:0]  exp_q [$];
    int          frames_expected = 0;
    int          frames_seen = 0;
    int          errors = 0;

    uart_link_top i_uart_link_top (
        .clk  (clk),
        .rstn (rstn),
        .rx   (rx),
        .tx   (tx)
    );

    always #2 clk = ~clk;

    // 16-bit fibonacci lfsr with taps 16, 14, 13 and 11
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic drive_bit(input logic v);
        @(negedge clk);
        rx = v;
        repeat (uart_link_pkg::CLKS_PER_BIT - 1) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(b[i]);
        drive_bit(1'b1);
    endtask

    // sum_skew corrupts the checksum when it is not zero
    task automatic send_command(input logic [7:0] cmd, input logic [7:0] len,
                                input logic [39:0] payload, input logic [7:0] sum_skew);
        logic [7:0] sum;
        sum = uart_link_pkg::START_FLAG + cmd + len;
        send_byte(uart_link_pkg::START_FLAG);
        send_byte(cmd);
        send_byte(len);
        for (int i = 0; i < len; i++) begin
            send_byte(payload[i*8 +: 8]);
            sum += payload[i*8 +: 8];
        end
        send_byte(sum + sum_skew);
    endtask

    task automatic expect_frame(input logic [7:0] res, input logic [31:0] data);
        logic [7:0] len;
        logic [7:0] sum;
        len = (res == uart_link_pkg::RES_PRINT) ? 8'd4 : 8'd0;
        sum = uart_link_pkg::START_FLAG + res + len;
        exp_q.push_back(uart_link_pkg::START_FLAG);
        exp_q.push_back(res);
        exp_q.push_back(len);
        for (int i = 0; i < len; i++) begin
            exp_q.push_back(data[i*8 +: 8]);
            sum += data[i*8 +: 8];
        end
        exp_q.push_back(sum);
        frames_expected++;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        expect_frame(uart_link_pkg::RES_ACK, '0);
        model_regs[addr[3:0]] = data;  // only the low four address bits count
        send_command(uart_link_pkg::CMD_WRITE, 8'd5, {data, addr}, 8'd0);
    endtask

    task automatic read_reg(input logic [7:0] addr);
        expect_frame(uart_link_pkg::RES_PRINT, model_regs[addr[3:0]]);
        send_command(uart_link_pkg::CMD_READ, 8'd1, {32'd0, addr}, 8'd0);
    endtask

    task automatic wait_responses();
        wait (frames_seen == frames_expected);
    endtask

    task automatic receive_byte(output logic [7:0] b);
        do @(negedge clk); while (tx !== 1'b0);
        repeat (uart_link_pkg::CLKS_PER_BIT / 2) @(negedge clk);
        assert (tx === 1'b0) else begin
            $display("start bit on tx did not last to its middle");
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (uart_link_pkg::CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (uart_link_pkg::CLKS_PER_BIT) @(negedge clk);
        assert (tx === 1'b1) else begin
            $display("stop bit on tx was not high");
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got);
        logic [7:0] exp;
        if (exp_q.size() == 0) begin
            $display("a byte arrived on tx while no response was pending");
            errors++;
        end else begin
            exp = exp_q.pop_front();
            assert (got === exp) else begin
                $display("ERROR %s expected %h got %h", name, exp, got);
                errors++;
            end
        end
    endtask

    initial begin : tx_monitor
        logic [7:0] b;
        logic [7:0] len;
        forever begin
            receive_byte(b);
            check_byte("tx_start", b);
            receive_byte(b);
            check_byte("tx_res", b);
            receive_byte(len);
            check_byte("tx_len", len);
            for (int i = 0; i < len; i++) begin
                receive_byte(b);
                check_byte("tx_payload", b);
            end
            receive_byte(b);
            check_byte("tx_checksum", b);
            frames_seen++;
        end
    end

    // 32 exchanges at most, each a 9-byte command and an 8-byte response of 10 bits per byte
    initial begin : watchdog
        #(32 * 17 * 10 * uart_link_pkg::CLKS_PER_BIT * 4 + 20000);
        $display("timeout: the expected response frames did not all arrive");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        logic [7:0]  addr;
        logic [31:0] data;
        int          assert_fails;
        rx   = 1'b1;
        rstn = 1'b0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        repeat (20 * uart_link_pkg::CLKS_PER_BIT) begin
            @(negedge clk);
            assert (tx === 1'b1) else begin
                $display("ERROR tx expected 1 got %h", tx);
                errors++;
            end
        end

        repeat (6) begin
            addr = 8'(random_bits(8));
            data = random_bits(32);
            write_reg(addr, data);
            wait_responses();
        end
        for (int a = 0; a < 16; a++) begin
            read_reg(a[7:0]);  // unwritten registers come back as zero
            wait_responses();
        end

        // bad checksum, unknown command and short write all answer nak
        addr = 8'h03;
        data = random_bits(32);
        expect_frame(uart_link_pkg::RES_NAK, '0);
        send_command(uart_link_pkg::CMD_WRITE, 8'd5, {data, addr}, 8'd1);
        wait_responses();
        expect_frame(uart_link_pkg::RES_NAK, '0);
        send_command(8'h33, 8'd1, {32'd0, addr}, 8'd0);
        wait_responses();
        expect_frame(uart_link_pkg::RES_NAK, '0);
        send_command(uart_link_pkg::CMD_WRITE, 8'd3, {data, addr}, 8'd0);
        wait_responses();
        read_reg(addr);
        wait_responses();

        // three commands without waiting so responses queue up
        addr = 8'(random_bits(8));
        data = random_bits(32);
        write_reg(addr, data);
        read_reg(addr);
        read_reg(addr ^ 8'h01);
        wait_responses();

        repeat (4 * uart_link_pkg::CLKS_PER_BIT) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("expected response bytes never arrived on tx");
            errors++;
        end

        assert_fails = i_uart_link_top.i_uart_tx_ctrl.i_uart_link_checker.fail_count;
        $display("closing: %0d frame errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/uart_link_pkg.sv
uart_rx/uart_rx.sv
uart_rx/uart_cmd_decode.sv
logic/uart_cmd_exec.sv
uart_tx/uart_tx_ctrl.sv
uart_tx/uart_tx.sv
logic/uart_link_top.sv
verification/uart_link_checker.sv
verification/uart_link_tb.sv

// ==== Bender.yml ====
package:
  name: uart_link

sources:
  - common/uart_link_pkg.sv
  - uart_rx/uart_rx.sv
  - uart_rx/uart_cmd_decode.sv
  - logic/uart_cmd_exec.sv
  - uart_tx/uart_tx_ctrl.sv
  - uart_tx/uart_tx.sv
  - logic/uart_link_top.sv
  - target: simulation
    files:
      - verification/uart_link_checker.sv
      - verification/uart_link_tb.sv
